// File: logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// cpu side
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	// block geometry
	localparam int BLOCK_W = 256;
	localparam int WORDS = BLOCK_W / WORD_W;
	localparam int OFFSET_W = 3;
	localparam int BLOCK_OFF_W = 5;

	// direct-mapped line geometry, index from bits 9:5
	localparam int INDEX_W = 5;
	localparam int TAG_W = ADDR_W - INDEX_W - BLOCK_OFF_W;
	localparam int LINES = 1 << INDEX_W;

	// backing memory, wraps on block address bits 12:5
	localparam int MEM_IDX_W = 8;
	localparam int MEM_BLOCKS = 1 << MEM_IDX_W;
	localparam int MEM_LATENCY = 4;
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_COMPARE,
		ST_WRITEBACK,
		ST_ALLOCATE,
		ST_RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/cache_sram.sv
`timescale 1ns/1ps
`default_nettype none

module cache_sram #(
	parameter int DATA_W = 32
) (
	input  logic                          clk,
	input  logic [cache_pkg::INDEX_W-1:0] addr_i,
	input  logic                          we_i,
	input  logic [DATA_W-1:0]             data_i,
	output logic [DATA_W-1:0]             data_o
);
	import cache_pkg::*;

	logic [DATA_W-1:0] mem [LINES];

	// write-first, so a line written in one cycle reads back new data in the next
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[addr_i] <= data_i;
			data_o <= data_i;
		end else begin
			data_o <= mem[addr_i];
		end
	end

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input  logic clk,
	input  logic rst_n_i,

	// cpu side
	input  logic cpu_cs_i,
	input  logic cpu_we_i,
	output logic cpu_ack_o,

	// datapath
	input  logic hit_i,
	input  logic dirty_i,
	output logic tag_we_o,
	output logic data_we_o,
	output logic fill_sel_o,
	output logic dirty_o,

	// backing memory
	input  logic mem_ack_i,
	output logic mem_cs_o,
	output logic mem_we_o
);
	import cache_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic mem_cs_q;
	logic mem_phase;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		tag_we_o = 1'b0;
		data_we_o = 1'b0;
		dirty_o = 1'b0;
		case (state_q)
			ST_IDLE: begin
				if (cpu_cs_i) begin
					state_d = ST_COMPARE;
				end
			end
			ST_COMPARE: begin
				if (hit_i) begin
					// write hit marks the line dirty
					if (cpu_we_i) begin
						tag_we_o = 1'b1;
						data_we_o = 1'b1;
						dirty_o = 1'b1;
					end
					state_d = ST_RESPOND;
				end else if (dirty_i) begin
					state_d = ST_WRITEBACK;
				end else begin
					state_d = ST_ALLOCATE;
				end
			end
			ST_WRITEBACK: begin
				if (mem_ack_i) begin
					state_d = ST_ALLOCATE;
				end
			end
			ST_ALLOCATE: begin
				// fill lands with a clean tag, then recheck
				if (mem_ack_i) begin
					tag_we_o = 1'b1;
					data_we_o = 1'b1;
					state_d = ST_COMPARE;
				end
			end
			ST_RESPOND: begin
				state_d = ST_IDLE;
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	assign mem_phase = (state_d == ST_WRITEBACK) || (state_d == ST_ALLOCATE);

	// registered strobe, drops for a cycle between write-back and fill
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_cs_q <= 1'b0;
		end else begin
			mem_cs_q <= mem_phase && !mem_ack_i;
		end
	end

	assign mem_cs_o = mem_cs_q;
	assign mem_we_o = (state_q == ST_WRITEBACK);
	assign fill_sel_o = (state_q == ST_ALLOCATE);
	assign cpu_ack_o = (state_q == ST_RESPOND);

endmodule

`default_nettype wire

// File: logic/l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache (
	input  logic                          clk,
	input  logic                          rst_n_i,

	// cpu side
	input  logic [cache_pkg::ADDR_W-1:0]  cpu_addr_i,
	input  logic                          cpu_cs_i,
	input  logic                          cpu_we_i,
	input  logic [cache_pkg::WORD_W-1:0]  cpu_data_i,
	output logic                          cpu_ack_o,
	output logic [cache_pkg::WORD_W-1:0]  cpu_data_o,

	// backing memory side
	output logic [cache_pkg::ADDR_W-1:0]  mem_addr_o,
	output logic                          mem_cs_o,
	output logic                          mem_we_o,
	input  logic                          mem_ack_i,
	input  logic [cache_pkg::BLOCK_W-1:0] mem_rdata_i,
	output logic [cache_pkg::BLOCK_W-1:0] mem_wdata_o
);
	import cache_pkg::*;

	logic [TAG_W-1:0] addr_tag;
	logic [INDEX_W-1:0] addr_index;
	logic [OFFSET_W-1:0] addr_offset;

	logic [LINES-1:0] valid_q;
	logic line_valid;
	logic line_dirty;
	logic hit;

	// tag entry is {dirty, tag}
	logic [TAG_W:0] tag_rd;
	logic [TAG_W:0] tag_wr;
	logic [BLOCK_W-1:0] blk_rd;
	logic [BLOCK_W-1:0] blk_wr;

	logic tag_we;
	logic data_we;
	logic fill_sel;
	logic dirty_set;
	logic mem_we;

	assign addr_tag = cpu_addr_i[ADDR_W-1 -: TAG_W];
	assign addr_index = cpu_addr_i[BLOCK_OFF_W +: INDEX_W];
	assign addr_offset = cpu_addr_i[BLOCK_OFF_W-OFFSET_W +: OFFSET_W];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else if (tag_we) begin
			valid_q[addr_index] <= 1'b1;
		end
	end

	// dirty bit of an invalid line is meaningless
	assign line_valid = valid_q[addr_index];
	assign line_dirty = line_valid && tag_rd[TAG_W];
	assign hit = line_valid && (tag_rd[TAG_W-1:0] == addr_tag);

	assign tag_wr = {dirty_set, addr_tag};

	always_comb begin
		if (fill_sel) begin
			blk_wr = mem_rdata_i;
		end else begin
			blk_wr = blk_rd;
			blk_wr[addr_offset*WORD_W +: WORD_W] = cpu_data_i;
		end
	end

	assign cpu_data_o = blk_rd[addr_offset*WORD_W +: WORD_W];

	// write-back goes to the victim's address, fill to the requested one
	assign mem_addr_o = mem_we ? {tag_rd[TAG_W-1:0], addr_index, {BLOCK_OFF_W{1'b0}}}
	                           : {addr_tag, addr_index, {BLOCK_OFF_W{1'b0}}};
	assign mem_wdata_o = blk_rd;
	assign mem_we_o = mem_we;

	cache_ctrl ctrl_inst (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.cpu_cs_i   (cpu_cs_i),
		.cpu_we_i   (cpu_we_i),
		.cpu_ack_o  (cpu_ack_o),
		.hit_i      (hit),
		.dirty_i    (line_dirty),
		.tag_we_o   (tag_we),
		.data_we_o  (data_we),
		.fill_sel_o (fill_sel),
		.dirty_o    (dirty_set),
		.mem_ack_i  (mem_ack_i),
		.mem_cs_o   (mem_cs_o),
		.mem_we_o   (mem_we)
	);

	cache_sram #(.DATA_W(TAG_W + 1)) tag_sram_inst (
		.clk    (clk),
		.addr_i (addr_index),
		.we_i   (tag_we),
		.data_i (tag_wr),
		.data_o (tag_rd)
	);

	cache_sram #(.DATA_W(BLOCK_W)) data_sram_inst (
		.clk    (clk),
		.addr_i (addr_index),
		.we_i   (data_we),
		.data_i (blk_wr),
		.data_o (blk_rd)
	);

endmodule

`default_nettype wire

// File: logic/block_mem.sv
`timescale 1ns/1ps
`default_nettype none

module block_mem (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic [cache_pkg::ADDR_W-1:0]  addr_i,
	input  logic                          cs_i,
	input  logic                          we_i,
	input  logic [cache_pkg::BLOCK_W-1:0] wdata_i,
	output logic                          ack_o,
	output logic [cache_pkg::BLOCK_W-1:0] rdata_o
);
	import cache_pkg::*;

	logic [BLOCK_W-1:0] mem [MEM_BLOCKS];
	logic [MEM_IDX_W-1:0] blk_idx;
	logic [LAT_W-1:0] lat_cnt;
	logic done;
	logic fire;

	// word w holds {~w, w}
	initial begin : init_mem
		logic [15:0] w;
		for (int b = 0; b < MEM_BLOCKS; b++) begin
			for (int j = 0; j < WORDS; j++) begin
				w = 16'(b * WORDS + j);
				mem[b][j*WORD_W +: WORD_W] = {~w, w};
			end
		end
	end

	assign blk_idx = addr_i[BLOCK_OFF_W +: MEM_IDX_W];
	assign fire = cs_i && !done && (lat_cnt == LAT_W'(MEM_LATENCY - 1));

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lat_cnt <= '0;
			done <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			ack_o <= fire;
			if (!cs_i) begin
				lat_cnt <= '0;
				done <= 1'b0;
			end else if (fire) begin
				// one ack per request, then hold until cs drops
				done <= 1'b1;
			end else if (!done) begin
				lat_cnt <= lat_cnt + 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (fire) begin
			if (we_i) begin
				mem[blk_idx] <= wdata_i;
			end else begin
				rdata_o <= mem[blk_idx];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  logic [cache_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic                         cpu_cs_i,
	input  logic                         cpu_we_i,
	input  logic [cache_pkg::WORD_W-1:0] cpu_data_i,
	output logic                         cpu_ack_o,
	output logic [cache_pkg::WORD_W-1:0] cpu_data_o
);
	import cache_pkg::*;

	// cache to backing memory
	logic [ADDR_W-1:0] mem_addr;
	logic mem_cs;
	logic mem_we;
	logic [BLOCK_W-1:0] mem_wdata;
	logic mem_ack;
	logic [BLOCK_W-1:0] mem_rdata;

	l1_cache l1_cache_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_cs_i    (cpu_cs_i),
		.cpu_we_i    (cpu_we_i),
		.cpu_data_i  (cpu_data_i),
		.cpu_ack_o   (cpu_ack_o),
		.cpu_data_o  (cpu_data_o),
		.mem_addr_o  (mem_addr),
		.mem_cs_o    (mem_cs),
		.mem_we_o    (mem_we),
		.mem_ack_i   (mem_ack),
		.mem_rdata_i (mem_rdata),
		.mem_wdata_o (mem_wdata)
	);

	block_mem block_mem_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.addr_i  (mem_addr),
		.cs_i    (mem_cs),
		.we_i    (mem_we),
		.wdata_i (mem_wdata),
		.ack_o   (mem_ack),
		.rdata_o (mem_rdata)
	);

endmodule

`default_nettype wire

// File: bench/mem_subsystem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_sva (
	input logic                         clk,
	input logic                         rst_n_i,
	input logic                         cpu_ack_i,
	input logic                         mem_cs_i,
	input logic                         mem_we_i,
	input logic [cache_pkg::ADDR_W-1:0] mem_addr_i,
	input logic                         mem_ack_i
);
	// count of failed assertions
	int fail_cnt;

	initial begin
		fail_cnt = 0;
	end

	cpu_ack_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		cpu_ack_i |=> !cpu_ack_i)
	else begin
		fail_cnt++;
		$error("cpu_ack_o held high for two cycles");
	end

	mem_ack_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_ack_i |=> !mem_ack_i)
	else begin
		fail_cnt++;
		$error("mem_ack held high for two cycles");
	end

	// request held steady until the memory answers
	mem_req_stable_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_cs_i && !mem_ack_i |=> mem_cs_i && $stable(mem_we_i) && $stable(mem_addr_i))
	else begin
		fail_cnt++;
		$error("memory request changed before mem_ack");
	end

	ack_during_mem_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(cpu_ack_i && mem_cs_i))
	else begin
		fail_cnt++;
		$error("cpu_ack_o high while mem_cs is high");
	end

endmodule

`default_nettype wire

// File: bench/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;
	import cache_pkg::*;

	logic clk;
	logic rst_n_i;
	logic [ADDR_W-1:0] cpu_addr_i;
	logic cpu_cs_i;
	logic cpu_we_i;
	logic [WORD_W-1:0] cpu_data_i;
	logic cpu_ack_o;
	logic [WORD_W-1:0] cpu_data_o;

	// reference copy of every word reachable through address bits 12:2
	logic [WORD_W-1:0] model [MEM_BLOCKS*WORDS];
	int pass_cnt;
	int fail_cnt;
	int test_errs;
	bit timed_out;

	mem_subsystem_top mem_subsystem_top_inst (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.cpu_addr_i (cpu_addr_i),
		.cpu_cs_i   (cpu_cs_i),
		.cpu_we_i   (cpu_we_i),
		.cpu_data_i (cpu_data_i),
		.cpu_ack_o  (cpu_ack_o),
		.cpu_data_o (cpu_data_o)
	);

	bind l1_cache mem_subsystem_sva sva_inst (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.cpu_ack_i  (cpu_ack_o),
		.mem_cs_i   (mem_cs_o),
		.mem_we_i   (mem_we_o),
		.mem_addr_i (mem_addr_o),
		.mem_ack_i  (mem_ack_i)
	);

	always #50 clk = ~clk;

	// word w starts as {~w, w} over 16-bit halves
	function automatic logic [WORD_W-1:0] init_word(input int w);
		logic [15:0] n;
		n = w[15:0];
		return {~n, n};
	endfunction

	function automatic logic [ADDR_W-1:0] rand_addr();
		logic [10:0] w;
		w = 11'($urandom());
		return {19'd0, w, 2'b00};
	endfunction

	// called 1 ns after a rising edge, returns 1 ns after the edge that ends the ack cycle
	task automatic cpu_access(input logic [ADDR_W-1:0] addr, input logic we,
		input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
		int cycles;
		bit acked;
		rdata = '0;
		if (timed_out) begin
			return;
		end
		cpu_addr_i = addr;
		cpu_we_i = we;
		cpu_data_i = wdata;
		cpu_cs_i = 1'b1;
		acked = 1'b0;
		cycles = 0;
		while (!acked && cycles < 200) begin
			@(negedge clk);
			if (cpu_ack_o) begin
				acked = 1'b1;
				rdata = cpu_data_o;
			end
			cycles++;
		end
		@(posedge clk);
		#1;
		if (!acked) begin
			$display("request to address %h got no acknowledge within 200 cycles", addr);
			timed_out = 1'b1;
			test_errs++;
		end
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		logic [WORD_W-1:0] unused;
		cpu_access(addr, 1'b1, data, unused);
		model[addr[12:2]] = data;
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] addr);
		logic [WORD_W-1:0] got;
		cpu_access(addr, 1'b0, '0, got);
		if (!timed_out && got !== model[addr[12:2]]) begin
			$display("[ERROR] cpu_data_o at address %h: expected %h, actual %h",
				addr, model[addr[12:2]], got);
			test_errs++;
		end
	endtask

	task automatic report_test(input string name);
		cpu_cs_i = 1'b0;
		cpu_we_i = 1'b0;
		@(posedge clk);
		#1;
		if (test_errs == 0 && !timed_out) begin
			pass_cnt++;
			$display("%s: passed", name);
		end else if (test_errs == 0) begin
			fail_cnt++;
			$display("%s: skipped after an earlier timeout", name);
		end else begin
			fail_cnt++;
			$display("%s: failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	initial begin
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] b;
		logic [WORD_W-1:0] d;
		int sva_fails;
		clk = 1'b0;
		rst_n_i = 1'b0;
		cpu_addr_i = '0;
		cpu_cs_i = 1'b0;
		cpu_we_i = 1'b0;
		cpu_data_i = '0;
		pass_cnt = 0;
		fail_cnt = 0;
		test_errs = 0;
		timed_out = 1'b0;
		void'($urandom(63));
		for (int i = 0; i < MEM_BLOCKS * WORDS; i++) begin
			model[i] = init_word(i);
		end
		repeat (5) @(posedge clk);
		#1;
		rst_n_i = 1'b1;

		for (int i = 0; i < 10; i++) begin
			read_check(rand_addr());
		end
		report_test("cold reads");

		a = rand_addr();
		d = $urandom();
		write_word(a, d);
		read_check(a);
		report_test("write then read");

		// two words of one block, the other six keep their initial values
		a = rand_addr() & ~32'h1f;
		write_word(a | 32'h04, $urandom());
		write_word(a | 32'h18, $urandom());
		for (int j = 0; j < WORDS; j++) begin
			read_check(a | 32'(j * 4));
		end
		report_test("neighbor words");

		// same index, different tag in bits 12:10
		a = rand_addr();
		b = a ^ (32'($urandom_range(7, 1)) << 10);
		write_word(a, $urandom());
		read_check(b);
		read_check(a);
		report_test("eviction");

		for (int i = 0; i < 400 && !timed_out; i++) begin
			a = rand_addr();
			if ($urandom_range(1) == 1) begin
				write_word(a, $urandom());
			end else begin
				read_check(a);
			end
		end
		report_test("random mix");

		sva_fails = mem_subsystem_top_inst.l1_cache_inst.sva_inst.fail_cnt;
		$display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
			pass_cnt, fail_cnt, sva_fails);
		if (fail_cnt == 0 && sva_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
logic/cache_pkg.sv
logic/cache_sram.sv
logic/cache_ctrl.sv
logic/l1_cache.sv
logic/block_mem.sv
logic/mem_subsystem_top.sv
bench/mem_subsystem_sva.sv
bench/mem_subsystem_tb.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - logic/cache_pkg.sv
  - logic/cache_sram.sv
  - logic/cache_ctrl.sv
  - logic/l1_cache.sv
  - logic/block_mem.sv
  - logic/mem_subsystem_top.sv
  - target: test
    files:
      - bench/mem_subsystem_sva.sv
      - bench/mem_subsystem_tb.sv
